// ==== console_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module console_sequencer
    import cpu_isa_pkg::*, ctrl_sig_pkg::*;
(
    input  logic      t3,
    input  logic      rst_n,
    input  sw_mode_t  sw,
    input  beat_t     w,
    output ctrl_bus_t console_ctrl,
    output logic      run_exec
);

    phase_e phase;
    logic   in_run;
    logic   set_phase;
    logic   clr_phase;  // Only write_reg leaves run phase

    assign in_run   = (phase == phase_run);
    assign run_exec = (sw == run_prog) && in_run;

    always_ff @(posedge t3 or negedge rst_n) begin
        if (!rst_n) begin
            phase <= phase_setup;
        end else if (set_phase) begin
            phase <= phase_run;
        end else if (clr_phase) begin
            phase <= phase_setup;
        end
    end

    always_comb begin
        console_ctrl = '0;
        set_phase    = 1'b0;
        clr_phase    = 1'b0;
        case (sw)
            write_mem: begin
                console_ctrl.lar       = w[1] && !in_run;  // Address from switches
                console_ctrl.memw      = w[1] && in_run;
                console_ctrl.arinc     = w[1] && in_run;
                console_ctrl.sbus      = w[1];
                console_ctrl.stop      = w[1];
                console_ctrl.short_cyc = w[1];
                console_ctrl.selctl    = w[1];
                set_phase              = w[1];
            end
            read_mem: begin
                console_ctrl.sbus      = w[1] && !in_run;
                console_ctrl.lar       = w[1] && !in_run;
                console_ctrl.mbus      = w[1] && in_run;
                console_ctrl.arinc     = w[1] && in_run;
                console_ctrl.stop      = w[1];
                console_ctrl.short_cyc = w[1];
                console_ctrl.selctl    = w[1];
                set_phase              = w[1] && !in_run;
            end
            read_reg: begin
                console_ctrl.selctl = w[1] || w[2];
                console_ctrl.stop   = w[1] || w[2];
                if (w[1]) begin
                    console_ctrl.sel = 4'b0001;  // R0 and R1
                end else if (w[2]) begin
                    console_ctrl.sel = 4'b1011;  // R2 and R3
                end
            end
            write_reg: begin
                console_ctrl.sbus   = w[1] || w[2];
                console_ctrl.selctl = w[1] || w[2];
                console_ctrl.drw    = w[1] || w[2];
                console_ctrl.stop   = w[1] || w[2];
                if (w[1]) begin
                    console_ctrl.sel = in_run ? 4'b1001 : 4'b0011;
                end else if (w[2]) begin
                    console_ctrl.sel = in_run ? 4'b1110 : 4'b0100;
                end
                set_phase = w[2] && !in_run;
                clr_phase = w[2] && in_run;
            end
            run_prog: begin
                if (!in_run) begin  // Load PC from switches
                    console_ctrl.lpc       = w[1];
                    console_ctrl.sbus      = w[1];
                    console_ctrl.short_cyc = w[1];
                    console_ctrl.stop      = w[1];
                    set_phase              = w[1];
                end
            end
            default: ;
        endcase
    end

    a_phase_needs_beat: assert property (
        @(posedge t3) disable iff (!rst_n)
        (w == '0) |=> $stable(phase)
    ) else $error("Console phase changed without an active beat");

endmodule

`default_nettype wire

// ==== cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

    localparam int opcode_w  = 4;  // IR 7..4
    localparam int sw_w      = 3;
    localparam int alu_fn_w  = 4;  // S3..S0
    localparam int reg_sel_w = 4;  // SEL3..SEL0

    typedef logic [opcode_w-1:0]  opcode_t;
    typedef logic [alu_fn_w-1:0]  alu_fn_t;
    typedef logic [reg_sel_w-1:0] reg_sel_t;

    // Console switch settings
    typedef enum logic [sw_w-1:0] {
        run_prog  = 3'b000,
        write_mem = 3'b001,
        read_mem  = 3'b010,
        read_reg  = 3'b011,
        write_reg = 3'b100
    } sw_mode_t;

    localparam opcode_t op_add = 4'd1;
    localparam opcode_t op_sub = 4'd2;
    localparam opcode_t op_and = 4'd3;
    localparam opcode_t op_inc = 4'd4;
    localparam opcode_t op_ld  = 4'd5;
    localparam opcode_t op_st  = 4'd6;
    localparam opcode_t op_jc  = 4'd7;
    localparam opcode_t op_jz  = 4'd8;
    localparam opcode_t op_jmp = 4'd9;
    localparam opcode_t op_out = 4'd10;  // 11 unused
    localparam opcode_t op_or  = 4'd12;
    localparam opcode_t op_xor = 4'd13;
    localparam opcode_t op_stp = 4'd14;

    localparam alu_fn_t alu_add      = 4'b1001;
    localparam alu_fn_t alu_sub      = 4'b0110;  // Same code as xor, M selects
    localparam alu_fn_t alu_and      = 4'b1011;
    localparam alu_fn_t alu_inc      = 4'b0000;
    localparam alu_fn_t alu_or       = 4'b1110;
    localparam alu_fn_t alu_xor      = 4'b0110;
    localparam alu_fn_t alu_pass_b   = 4'b1010;
    localparam alu_fn_t alu_all_ones = 4'b1111;

endpackage

`default_nettype wire

// ==== ctrl_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module ctrl_select
    import ctrl_sig_pkg::*;
(
    input  beat_t     w,
    input  logic      run_exec,
    input  ctrl_bus_t console_ctrl,
    input  ctrl_bus_t beat2_ctrl,
    input  ctrl_bus_t beat3_ctrl,
    output ctrl_bus_t ctrl
);

    always_comb begin
        ctrl = '0;
        if (!run_exec) begin
            ctrl = console_ctrl;  // Already beat gated
        end else if (w[1]) begin
            ctrl.lir   = 1'b1;  // Fetch
            ctrl.pcinc = 1'b1;
        end else if (w[2]) begin
            ctrl = beat2_ctrl;
        end else if (w[3]) begin
            ctrl = beat3_ctrl;
        end
    end

    // Console and decode bundles must never combine into a bad cycle
    always_comb begin
        a_cyc_len_excl: assert final (!(ctrl.short_cyc && ctrl.long_cyc))
            else $error("short_cyc and long_cyc both active");
        a_write_excl: assert final (!(ctrl.drw && ctrl.memw))
            else $error("drw and memw both active");
    end

endmodule

`default_nettype wire

// ==== ctrl_sig_pkg.sv ====
`default_nettype none

package ctrl_sig_pkg;

    import cpu_isa_pkg::*;

    localparam int beat_w = 3;

    // Timing beats, bit n is Wn
    typedef logic [beat_w:1] beat_t;

    // Console phase, the ST0 flag
    typedef enum logic {
        phase_setup = 1'b0,
        phase_run   = 1'b1
    } phase_e;

    // One beat's datapath controls
    typedef struct packed {
        logic     ldc;
        logic     ldz;
        logic     cin;
        alu_fn_t  s;
        reg_sel_t sel;
        logic     m;
        logic     abus;
        logic     drw;
        logic     pcinc;
        logic     lpc;
        logic     lar;
        logic     pcadd;
        logic     arinc;
        logic     selctl;
        logic     memw;
        logic     stop;
        logic     lir;
        logic     sbus;
        logic     mbus;
        logic     short_cyc;  // Skip W2 and W3
        logic     long_cyc;   // Add W3
    } ctrl_bus_t;

endpackage

`default_nettype wire

// ==== hdcpu_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdcpu_ctrl
    import cpu_isa_pkg::*, ctrl_sig_pkg::*;
(
    input  logic      t3,
    input  logic      rst_n,
    input  sw_mode_t  sw,
    input  opcode_t   ir,
    input  beat_t     w,
    input  logic      c,
    input  logic      z,
    output ctrl_bus_t ctrl
);

    ctrl_bus_t console_ctrl;
    ctrl_bus_t beat2_ctrl;
    ctrl_bus_t beat3_ctrl;
    logic      run_exec;

    console_sequencer u_console (
        .t3           (t3),
        .rst_n        (rst_n),
        .sw           (sw),
        .w            (w),
        .console_ctrl (console_ctrl),
        .run_exec     (run_exec)
    );

    instr_decode u_decode (
        .ir         (ir),
        .c          (c),
        .z          (z),
        .beat2_ctrl (beat2_ctrl),
        .beat3_ctrl (beat3_ctrl)
    );

    ctrl_select u_select (
        .w            (w),
        .run_exec     (run_exec),
        .console_ctrl (console_ctrl),
        .beat2_ctrl   (beat2_ctrl),
        .beat3_ctrl   (beat3_ctrl),
        .ctrl         (ctrl)
    );

endmodule

`default_nettype wire

// ==== instr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decode
    import cpu_isa_pkg::*, ctrl_sig_pkg::*;
(
    input  opcode_t   ir,
    input  logic      c,
    input  logic      z,
    output ctrl_bus_t beat2_ctrl,
    output ctrl_bus_t beat3_ctrl
);

    always_comb begin
        beat2_ctrl = '0;
        beat3_ctrl = '0;
        case (ir)
            op_add: begin
                beat2_ctrl.s    = alu_add;
                beat2_ctrl.cin  = 1'b1;
                beat2_ctrl.abus = 1'b1;
                beat2_ctrl.drw  = 1'b1;
                beat2_ctrl.ldz  = 1'b1;
                beat2_ctrl.ldc  = 1'b1;
            end
            op_sub: begin
                beat2_ctrl.s    = alu_sub;
                beat2_ctrl.abus = 1'b1;
                beat2_ctrl.drw  = 1'b1;
                beat2_ctrl.ldz  = 1'b1;
                beat2_ctrl.ldc  = 1'b1;
            end
            op_inc: begin
                beat2_ctrl.s    = alu_inc;
                beat2_ctrl.abus = 1'b1;
                beat2_ctrl.drw  = 1'b1;
                beat2_ctrl.ldz  = 1'b1;
                beat2_ctrl.ldc  = 1'b1;
            end
            op_and, op_or, op_xor: begin  // Logic ops leave carry alone
                beat2_ctrl.s    = (ir == op_and) ? alu_and :
                                  (ir == op_or)  ? alu_or  : alu_xor;
                beat2_ctrl.m    = 1'b1;
                beat2_ctrl.abus = 1'b1;
                beat2_ctrl.drw  = 1'b1;
                beat2_ctrl.ldz  = 1'b1;
            end
            op_ld: begin
                beat2_ctrl.s        = alu_pass_b;
                beat2_ctrl.m        = 1'b1;
                beat2_ctrl.abus     = 1'b1;
                beat2_ctrl.lar      = 1'b1;
                beat2_ctrl.long_cyc = 1'b1;
                beat3_ctrl.drw      = 1'b1;  // Memory data into Rd
                beat3_ctrl.mbus     = 1'b1;
            end
            op_st: begin
                beat2_ctrl.s        = alu_all_ones;  // Address from Rs
                beat2_ctrl.m        = 1'b1;
                beat2_ctrl.abus     = 1'b1;
                beat2_ctrl.lar      = 1'b1;
                beat2_ctrl.long_cyc = 1'b1;
                beat3_ctrl.s        = alu_pass_b;
                beat3_ctrl.m        = 1'b1;
                beat3_ctrl.abus     = 1'b1;
                beat3_ctrl.memw     = 1'b1;
            end
            op_jc: begin
                beat2_ctrl.pcadd = c;
            end
            op_jz: begin
                beat2_ctrl.pcadd = z;
            end
            op_jmp: begin
                beat2_ctrl.s    = alu_all_ones;
                beat2_ctrl.m    = 1'b1;
                beat2_ctrl.abus = 1'b1;
                beat2_ctrl.lpc  = 1'b1;
            end
            op_out: begin
                beat2_ctrl.s    = alu_pass_b;
                beat2_ctrl.m    = 1'b1;
                beat2_ctrl.abus = 1'b1;
            end
            op_stp: begin
                beat2_ctrl.stop = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hdcpu_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module tb_hdcpu_ctrl \
        -o tb_sim > build.log 2>&1; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== sources.f ====
+incdir+.
cpu_isa_pkg.sv
ctrl_sig_pkg.sv
console_sequencer.sv
instr_decode.sv
ctrl_select.sv
hdcpu_ctrl.sv
tb_hdcpu_ctrl.sv

// ==== tb_ctrl_model.svh ====
`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

// Console bundles, already gated by the beat
function automatic ctrl_bus_t console_bundle(input sw_mode_t mode, input logic in_run,
                                             input beat_t beat);
    ctrl_bus_t b;
    b = '0;
    case (mode)
        write_mem, read_mem: begin
            if (beat[1]) begin
                b.stop      = 1'b1;
                b.short_cyc = 1'b1;
                b.selctl    = 1'b1;
                b.lar       = !in_run;
                b.arinc     = in_run;
                b.sbus      = (mode == write_mem) || !in_run;
                b.memw      = (mode == write_mem) && in_run;
                b.mbus      = (mode == read_mem) && in_run;
            end
        end
        read_reg: begin
            if (beat[1] || beat[2]) begin
                b.selctl = 1'b1;
                b.stop   = 1'b1;
                b.sel    = beat[1] ? 4'b0001 : 4'b1011;
            end
        end
        write_reg: begin
            if (beat[1] || beat[2]) begin
                b.sbus   = 1'b1;
                b.selctl = 1'b1;
                b.drw    = 1'b1;
                b.stop   = 1'b1;
                case ({in_run, beat[2]})
                    2'b00:   b.sel = 4'b0011;
                    2'b01:   b.sel = 4'b0100;
                    2'b10:   b.sel = 4'b1001;
                    default: b.sel = 4'b1110;
                endcase
            end
        end
        run_prog: begin
            if (beat[1] && !in_run) begin  // PC load
                b.lpc       = 1'b1;
                b.sbus      = 1'b1;
                b.short_cyc = 1'b1;
                b.stop      = 1'b1;
            end
        end
        default: ;
    endcase
    return b;
endfunction

function automatic phase_e next_phase(input sw_mode_t mode, input phase_e ph, input beat_t beat);
    phase_e nxt;
    nxt = ph;
    if (mode == write_reg && beat[2]) begin
        nxt = (ph == phase_run) ? phase_setup : phase_run;
    end else if ((mode inside {run_prog, write_mem, read_mem}) && beat[1]) begin
        nxt = phase_run;
    end
    return nxt;
endfunction

// Opcode table, W2 bundle or W3 bundle
function automatic ctrl_bus_t decode_bundle(input opcode_t op, input logic cf, input logic zf,
                                            input logic third);
    ctrl_bus_t b2;
    ctrl_bus_t b3;
    b2 = '0;
    b3 = '0;
    case (op)
        op_add: b2 = '{s: alu_add, cin: 1'b1, abus: 1'b1, drw: 1'b1, ldz: 1'b1, ldc: 1'b1,
                       default: '0};
        op_sub: b2 = '{s: alu_sub, abus: 1'b1, drw: 1'b1, ldz: 1'b1, ldc: 1'b1, default: '0};
        op_inc: b2 = '{s: alu_inc, abus: 1'b1, drw: 1'b1, ldz: 1'b1, ldc: 1'b1, default: '0};
        op_and: b2 = '{s: alu_and, m: 1'b1, abus: 1'b1, drw: 1'b1, ldz: 1'b1, default: '0};
        op_or:  b2 = '{s: alu_or, m: 1'b1, abus: 1'b1, drw: 1'b1, ldz: 1'b1, default: '0};
        op_xor: b2 = '{s: alu_xor, m: 1'b1, abus: 1'b1, drw: 1'b1, ldz: 1'b1, default: '0};
        op_ld: begin
            b2 = '{s: alu_pass_b, m: 1'b1, abus: 1'b1, lar: 1'b1, long_cyc: 1'b1, default: '0};
            b3 = '{drw: 1'b1, mbus: 1'b1, default: '0};
        end
        op_st: begin
            b2 = '{s: alu_all_ones, m: 1'b1, abus: 1'b1, lar: 1'b1, long_cyc: 1'b1,
                   default: '0};
            b3 = '{s: alu_pass_b, m: 1'b1, abus: 1'b1, memw: 1'b1, default: '0};
        end
        op_jc:  b2.pcadd = cf;
        op_jz:  b2.pcadd = zf;
        op_jmp: b2 = '{s: alu_all_ones, m: 1'b1, abus: 1'b1, lpc: 1'b1, default: '0};
        op_out: b2 = '{s: alu_pass_b, m: 1'b1, abus: 1'b1, default: '0};
        op_stp: b2.stop = 1'b1;
        default: ;
    endcase
    return third ? b3 : b2;
endfunction

function automatic ctrl_bus_t expect_bundle(input sw_mode_t mode, input phase_e ph,
                                            input opcode_t op, input logic cf, input logic zf,
                                            input beat_t beat);
    ctrl_bus_t b;
    b = '0;
    if (mode != run_prog || ph == phase_setup) begin
        b = console_bundle(mode, ph == phase_run, beat);
    end else if (beat[1]) begin
        b.lir   = 1'b1;  // Fetch
        b.pcinc = 1'b1;
    end else if (beat[2] || beat[3]) begin
        b = decode_bundle(op, cf, zf, beat[3]);
    end
    return b;
endfunction

`endif

// ==== tb_hdcpu_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_hdcpu_ctrl
    import cpu_isa_pkg::*, ctrl_sig_pkg::*;
();

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 16;
    localparam int n_tests         = 5;
    localparam int n_ops           = 40;
    localparam int watchdog_cycles = (n_tests + 1) * reset_cycles + n_tests * 40 + n_ops * 3;
    localparam ctrl_bus_t no_ctrl  = '0;

    logic        t3;
    logic        rst_n;
    sw_mode_t    sw;
    opcode_t     ir;
    beat_t       w;
    logic        c;
    logic        z;
    ctrl_bus_t   ctrl;
    phase_e      model_phase;
    ctrl_bus_t   exp_ctrl;
    logic [15:0] lfsr_state;
    string       test_name;
    int          err_count;
    int          errs_at_start;
    int          tests_failed;

    `include "tb_ctrl_model.svh"

    hdcpu_ctrl DUT (
        .t3    (t3),
        .rst_n (rst_n),
        .sw    (sw),
        .ir    (ir),
        .w     (w),
        .c     (c),
        .z     (z),
        .ctrl  (ctrl)
    );

    always #(clk_period / 2) t3 = ~t3;

    always @(posedge t3 or negedge rst_n) begin
        if (!rst_n) begin
            model_phase <= phase_setup;
        end else begin
            model_phase <= next_phase(sw, model_phase, w);
        end
    end

    always_comb begin
        exp_ctrl = expect_bundle(sw, model_phase, ir, c, z, w);
    end

    a_ctrl_matches: assert property (
        @(posedge t3) disable iff (!rst_n) ctrl == exp_ctrl
    ) else begin
        err_count++;
        $display("Fail %s: expected %h, actual %h", test_name,
                 $sampled(exp_ctrl), $sampled(ctrl));
    end

    a_idle_zero: assert property (
        @(posedge t3) disable iff (!rst_n) (w == '0) |-> (ctrl == '0)
    ) else begin
        err_count++;
        $display("Fail %s: expected %h, actual %h with no beat", test_name,
                 no_ctrl, $sampled(ctrl));
    end

    task automatic apply_reset();
        @(negedge t3);
        w     = '0;
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge t3);
        rst_n = 1'b1;
    endtask

    // W1, W2, W3 on three successive cycles
    task automatic run_beats(input sw_mode_t mode, input opcode_t op, input logic cf,
                             input logic zf);
        beat_t beat;
        beat = 3'b001;
        for (int i = 0; i < 3; i++) begin
            @(negedge t3);
            sw   = mode;
            ir   = op;
            c    = cf;
            z    = zf;
            w    = beat;
            beat = beat << 1;
        end
    endtask

    task automatic idle_beat();
        @(negedge t3);
        w = '0;
    endtask

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[6:0], lfsr_state[0]};
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test();
        int errs;
        idle_beat();
        @(negedge t3);  // Last beat checked by now
        errs = err_count - errs_at_start;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %s finished with %0d errors", test_name, errs);
    endtask

    initial begin
        logic [7:0] bits;
        t3           = 1'b0;
        rst_n        = 1'b0;
        sw           = run_prog;
        ir           = '0;
        w            = '0;
        c            = 1'b0;
        z            = 1'b0;
        lfsr_state   = 16'd4916;
        err_count    = 0;
        tests_failed = 0;
        test_name    = "reset";
        apply_reset();

        start_test("write_mem");
        repeat (4) run_beats(write_mem, '0, 1'b0, 1'b0);
        end_test();

        apply_reset();
        start_test("read_mem");
        repeat (4) run_beats(read_mem, '0, 1'b0, 1'b0);
        end_test();

        apply_reset();
        start_test("registers");
        repeat (2) run_beats(read_reg, '0, 1'b0, 1'b0);
        repeat (3) run_beats(write_reg, '0, 1'b0, 1'b0);  // Third pass back in setup
        end_test();

        apply_reset();
        start_test("run_prog");
        run_beats(run_prog, '0, 1'b0, 1'b0);
        for (int i = 0; i < n_ops; i++) begin
            take_bits(6, bits);
            run_beats(run_prog, bits[5:2], bits[1], bits[0]);
        end
        end_test();

        apply_reset();
        start_test("reset_in_run");
        run_beats(run_prog, '0, 1'b0, 1'b0);
        run_beats(run_prog, op_st, 1'b1, 1'b0);
        apply_reset();
        run_beats(run_prog, op_add, 1'b0, 1'b1);  // PC load again
        idle_beat();
        idle_beat();
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", n_tests, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
